//--- cu_copy.f
verilog/cu_pkg.sv
verilog/cu_line_fifo.sv
verilog/cu_read_engine.sv
verilog/cu_write_engine.sv
verilog/cu_control.sv
test/cu_tb_clock.sv
test/cu_memory_model.sv
test/cu_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the copy compute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module cu_tb -f cu_copy.f -o cu_tb_sim \
	&& ./obj_dir/cu_tb_sim > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

//--- test/cu_memory_model.sv
/*
 * Host memory model
 * Answers read and write commands in order after 2 to 8 cycles,
 * holds a random source image and records every write
 */

`timescale 1ns/1ps
`default_nettype none

module cu_memory_model
	import cu_pkg::*;
#(
	parameter addr_t SOURCE_BASE = 64'h0,
	parameter addr_t DEST_BASE   = 64'h0,
	parameter int    LINES       = 32
) (
	input  wire logic          clock,
	input  wire logic          rstn,
	input  wire logic          read_command_valid,
	input  wire command_line_t read_command,
	input  wire logic          write_command_valid,
	input  wire command_line_t write_command,
	input  wire data_line_t    write_data,
	output logic               read_response_valid,
	output response_line_t     read_response,
	output logic               read_data_valid,
	output data_line_t         read_data,
	output tag_t               read_data_tag,
	output logic               write_response_valid,
	output response_line_t     write_response
);

	data_line_t source_mem [LINES];
	data_line_t dest_mem   [LINES];

	// Pending answers, oldest first
	addr_t  read_addrs [$];
	tag_t   read_tags  [$];
	longint read_due   [$];
	tag_t   write_tags [$];
	longint write_due  [$];

	longint cycle;
	longint last_read_due;
	longint last_write_due;
	int     seed;

	// Random latency that never overtakes an older answer
	function automatic longint next_due(input longint last);
		longint due;
		due = cycle + 2 + longint'($unsigned($random(seed)) % 7);
		if (due <= last) begin
			due = last + 1;
		end
		return due;
	endfunction

	function automatic int line_index(input addr_t address, input addr_t base);
		addr_t offset;
		offset = (address - base) >> 6;
		if (address < base || offset >= addr_t'(LINES)) begin
			return -1;
		end
		return int'(offset);
	endfunction

	initial begin
		read_response_valid  = 1'b0;
		read_response        = '0;
		read_data_valid      = 1'b0;
		read_data            = '0;
		read_data_tag        = '0;
		write_response_valid = 1'b0;
		write_response       = '0;
	end

	always @(posedge clock) begin : answer
		addr_t address;
		tag_t  tag;
		int    index;
		if (!rstn) begin
			// Same source image after every reset
			seed = 42;
			for (int i = 0; i < LINES; i++) begin
				dest_mem[i] = '0;
				for (int w = 0; w < 16; w++) begin
					source_mem[i][w*32 +: 32] = $random(seed);
				end
			end
			read_addrs.delete();
			read_tags.delete();
			read_due.delete();
			write_tags.delete();
			write_due.delete();
			cycle          = 0;
			last_read_due  = 0;
			last_write_due = 0;
			read_response_valid  <= 1'b0;
			read_data_valid      <= 1'b0;
			write_response_valid <= 1'b0;
		end else begin
			cycle = cycle + 1;
			read_response_valid  <= 1'b0;
			read_data_valid      <= 1'b0;
			write_response_valid <= 1'b0;
			if (read_command_valid) begin
				last_read_due = next_due(last_read_due);
				read_due.push_back(last_read_due);
				read_addrs.push_back(read_command.address);
				read_tags.push_back(read_command.tag);
			end
			if (write_command_valid) begin
				index = line_index(write_command.address, DEST_BASE);
				if (index >= 0) begin
					dest_mem[index] = write_data;
				end
				last_write_due = next_due(last_write_due);
				write_due.push_back(last_write_due);
				write_tags.push_back(write_command.tag);
			end
			// Data travels with its read response
			if (read_due.size() > 0 && read_due[0] <= cycle) begin
				void'(read_due.pop_front());
				address = read_addrs.pop_front();
				tag     = read_tags.pop_front();
				index   = line_index(address, SOURCE_BASE);
				read_response_valid <= 1'b1;
				read_response.tag   <= tag;
				read_data_valid     <= 1'b1;
				read_data           <= (index < 0) ? '0 : source_mem[index];
				read_data_tag       <= tag;
			end
			if (write_due.size() > 0 && write_due[0] <= cycle) begin
				void'(write_due.pop_front());
				write_response_valid <= 1'b1;
				write_response.tag   <= write_tags.pop_front();
			end
		end
	end

endmodule

`default_nettype wire

//--- test/cu_tb.sv
/*
 * Copy compute unit testbench
 * Runs a read-only and a copy job against the memory model and
 * checks commands, credits, written lines, status and completion
 */

`timescale 1ns/1ps
`default_nettype none

module cu_tb
	import cu_pkg::*;
();

	localparam int          MAX_OUTSTANDING = 4;
	localparam int          FIFO_DEPTH      = 8;
	localparam int          LINES           = 32;
	localparam int          DONE_TIMEOUT    = 2000;
	localparam int          RESET_TIMEOUT   = 20;
	localparam addr_t       SRC_BASE        = 64'h0000_0000_0004_0000;
	localparam addr_t       DST_BASE        = 64'h0000_0000_0008_0000;
	localparam logic [63:0] CFG_COPY        = 64'h0000_0000_00C0_0015;
	localparam logic [63:0] CFG_READ_ONLY   = 64'h0000_0002_0080_0003;

	logic           clock;
	logic           rstn;
	logic           reset_request;
	logic           enabled_in;
	logic           wed_valid;
	wed_t           wed;
	logic [63:0]    cu_configure;
	logic           read_response_valid;
	response_line_t read_response;
	logic           read_data_valid;
	data_line_t     read_data;
	tag_t           read_data_tag;
	logic           write_response_valid;
	response_line_t write_response;
	logic           read_command_valid;
	command_line_t  read_command;
	logic           write_command_valid;
	command_line_t  write_command;
	data_line_t     write_data;
	logic [63:0]    cu_return;
	logic           cu_done;
	logic [63:0]    cu_status;

	data_line_t expected_image [LINES];
	count_t     reads_seen;
	count_t     writes_seen;
	int         reads_open;
	int         writes_open;
	int         error_count   = 0;
	int         timeout_count = 0;

	cu_tb_clock i_clock (
		.reset_request (reset_request),
		.clock         (clock),
		.rstn          (rstn)
	);

	cu_memory_model #(
		.SOURCE_BASE (SRC_BASE),
		.DEST_BASE   (DST_BASE),
		.LINES       (LINES)
	) i_memory_model (
		.clock                (clock),
		.rstn                 (rstn),
		.read_command_valid   (read_command_valid),
		.read_command         (read_command),
		.write_command_valid  (write_command_valid),
		.write_command        (write_command),
		.write_data           (write_data),
		.read_response_valid  (read_response_valid),
		.read_response        (read_response),
		.read_data_valid      (read_data_valid),
		.read_data            (read_data),
		.read_data_tag        (read_data_tag),
		.write_response_valid (write_response_valid),
		.write_response       (write_response)
	);

	cu_control #(
		.MAX_OUTSTANDING (MAX_OUTSTANDING),
		.FIFO_DEPTH      (FIFO_DEPTH)
	) i_cu_control (
		.clock                (clock),
		.rstn                 (rstn),
		.enabled_in           (enabled_in),
		.wed_valid            (wed_valid),
		.wed                  (wed),
		.cu_configure         (cu_configure),
		.read_response_valid  (read_response_valid),
		.read_response        (read_response),
		.read_data_valid      (read_data_valid),
		.read_data            (read_data),
		.read_data_tag        (read_data_tag),
		.write_response_valid (write_response_valid),
		.write_response       (write_response),
		.read_command_valid   (read_command_valid),
		.read_command         (read_command),
		.write_command_valid  (write_command_valid),
		.write_command        (write_command),
		.write_data           (write_data),
		.cu_return            (cu_return),
		.cu_done              (cu_done),
		.cu_status            (cu_status)
	);

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_data_line(input string name, input data_line_t actual,
		input data_line_t expected);
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_count(input string name, input count_t actual, input count_t expected);
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic check_address(input string name, input addr_t actual, input addr_t expected);
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, actual, expected);
		end
	endtask

	// cu_return and cu_status are 64-bit words
	task automatic check_word(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
		end
	endtask

	////////////////////
	// Reference model
	////////////////////

	// Fills the expected destination image and returns the expected line count
	function automatic count_t reference_run(input logic copy, input count_t size_send,
		input count_t size_recive);
		for (int i = 0; i < LINES; i++) begin
			if (copy && count_t'(i) < size_recive) begin
				expected_image[i] = i_memory_model.source_mem[i];
			end else begin
				expected_image[i] = '0;
			end
		end
		return copy ? size_recive : size_send;
	endfunction

	////////////////////
	// Port monitor
	////////////////////

	always @(negedge clock) begin : port_monitor
		int reads_next;
		int writes_next;
		if (!rstn) begin
			reads_seen  <= '0;
			writes_seen <= '0;
			reads_open  <= 0;
			writes_open <= 0;
		end else begin
			reads_next  = reads_open + int'(read_command_valid) - int'(read_response_valid);
			writes_next = writes_open + int'(write_command_valid) - int'(write_response_valid);
			check_bit("read credit within limit", reads_next <= MAX_OUTSTANDING, 1'b1);
			check_bit("write credit within limit", writes_next <= MAX_OUTSTANDING, 1'b1);
			reads_open  <= reads_next;
			writes_open <= writes_next;
			if (read_command_valid) begin
				check_address("read_command.address", read_command.address,
					SRC_BASE + addr_t'(reads_seen) * addr_t'(LINE_BYTES));
				check_count("read_command.tag", count_t'(read_command.tag),
					count_t'(tag_t'(reads_seen)));
				reads_seen <= reads_seen + 1'b1;
			end
			if (write_command_valid) begin
				check_address("write_command.address", write_command.address,
					DST_BASE + addr_t'(writes_seen) * addr_t'(LINE_BYTES));
				check_count("write_command.tag", count_t'(write_command.tag),
					count_t'(tag_t'(writes_seen)));
				writes_seen <= writes_seen + 1'b1;
			end
		end
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	task automatic skip_cycles(input int cycles);
		repeat (cycles) @(negedge clock);
	endtask

	task automatic wait_for_reset_level(input logic level, output logic ok);
		ok = 1'b0;
		for (int i = 0; i < RESET_TIMEOUT && !ok; i++) begin
			@(negedge clock);
			ok = (rstn === level);
		end
		if (!ok) begin
			timeout_count++;
			$display("Timeout: reset did not reach level %b", level);
		end
	endtask

	task automatic wait_for_done(output logic ok);
		ok = 1'b0;
		for (int i = 0; i < DONE_TIMEOUT && !ok; i++) begin
			@(negedge clock);
			ok = (cu_done === 1'b1);
		end
		if (!ok) begin
			timeout_count++;
			$display("Timeout: cu_done did not rise within %0d cycles", DONE_TIMEOUT);
		end
	endtask

	task automatic restart_dut(output logic ok);
		@(posedge clock);
		enabled_in    <= 1'b0;
		reset_request <= 1'b1;
		@(posedge clock);
		reset_request <= 1'b0;
		wait_for_reset_level(1'b0, ok);
		if (ok) begin
			wait_for_reset_level(1'b1, ok);
		end
	endtask

	task automatic send_wed(input count_t lines);
		wed_t descriptor;
		descriptor                     = '0;
		descriptor.valid               = 1'b1;
		descriptor.source_address      = SRC_BASE;
		descriptor.destination_address = DST_BASE;
		descriptor.size_send           = lines;
		descriptor.size_recive         = lines;
		@(posedge clock);
		wed_valid <= 1'b1;
		wed       <= descriptor;
		@(posedge clock);
		wed_valid <= 1'b0;
	endtask

	// One cycle of configuration, then zero again
	task automatic send_config(input logic [63:0] value);
		@(posedge clock);
		cu_configure <= value;
		@(posedge clock);
		cu_configure <= '0;
	endtask

	task automatic run_case(input logic [63:0] cfg, input logic [63:0] decoy,
		input count_t lines, input logic wed_first, output logic ok);
		logic   copy;
		count_t expected_return;
		copy            = cfg[CFG_READ_BIT] && cfg[CFG_WRITE_BIT];
		expected_return = reference_run(copy, lines, lines);
		check_bit("read_command_valid", read_command_valid, 1'b0);
		check_bit("write_command_valid", write_command_valid, 1'b0);
		check_bit("cu_done", cu_done, 1'b0);
		check_word("cu_return", cu_return, 64'h0);
		check_word("cu_status", cu_status, 64'h0);
		@(posedge clock);
		enabled_in <= 1'b1;
		skip_cycles(4);
		check_count("read commands while idle", reads_seen, '0);
		// Only half of the setup given here
		if (wed_first) begin
			send_wed(lines);
		end else begin
			send_config(decoy);
			send_config(cfg);
		end
		skip_cycles(6);
		check_count("read commands before start", reads_seen, '0);
		check_count("write commands before start", writes_seen, '0);
		if (wed_first) begin
			send_config(cfg);
		end else begin
			check_word("cu_status", cu_status, cfg);
			send_wed(lines);
		end
		wait_for_done(ok);
		if (ok) begin
			skip_cycles(4);
			check_bit("cu_done", cu_done, 1'b1);
			check_word("cu_return", cu_return, 64'(expected_return));
			check_word("cu_status", cu_status, cfg);
			check_count("read commands", reads_seen, lines);
			check_count("write commands", writes_seen, copy ? lines : '0);
			check_count("reads outstanding", count_t'(reads_open), '0);
			check_count("writes outstanding", count_t'(writes_open), '0);
			for (int i = 0; i < LINES; i++) begin
				check_data_line($sformatf("dest_mem[%0d]", i), i_memory_model.dest_mem[i],
					expected_image[i]);
			end
		end
	endtask

	task automatic finish_run();
		$display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin : stimulus
		logic ok;
		reset_request = 1'b0;
		enabled_in    = 1'b0;
		wed_valid     = 1'b0;
		wed           = '0;
		cu_configure  = '0;
		wait_for_reset_level(1'b1, ok);
		// Read-only job configured before its WED
		if (ok) begin
			run_case(CFG_READ_ONLY, CFG_COPY, 32'd12, 1'b0, ok);
		end
		if (ok) begin
			restart_dut(ok);
		end
		// Copy job with the WED ahead of the configuration
		if (ok) begin
			run_case(CFG_COPY, 64'h0, 32'd20, 1'b1, ok);
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- test/cu_tb_clock.sv
/*
 * Testbench clock and reset
 * 40 ns clock, active-low reset held for four cycles at start
 * and again whenever a restart is requested
 */

`timescale 1ns/1ps
`default_nettype none

module cu_tb_clock #(
	parameter int HALF_PERIOD  = 20,
	parameter int RESET_CYCLES = 4
) (
	input  wire logic reset_request,
	output logic      clock,
	output logic      rstn
);

	logic reset_active = 1'b1;
	int   reset_left   = RESET_CYCLES;

	assign rstn = !reset_active;

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

	// Reset released on the last counted edge
	always @(posedge clock) begin
		if (reset_request) begin
			reset_active <= 1'b1;
			reset_left   <= RESET_CYCLES;
		end else if (reset_left > 0) begin
			reset_left <= reset_left - 1;
			if (reset_left == 1) begin
				reset_active <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/cu_control.sv
/*
 * Copy compute unit top level
 * Latches WED and configuration, starts the read and write
 * engines and reports line count and completion
 */

`timescale 1ns/1ps
`default_nettype none

module cu_control
	import cu_pkg::*;
#(
	parameter int MAX_OUTSTANDING = 4,
	parameter int FIFO_DEPTH      = 8
) (
	input  wire logic           clock,
	input  wire logic           rstn,
	input  wire logic           enabled_in,
	input  wire logic           wed_valid,
	input  wire wed_t           wed,
	input  wire logic [63:0]    cu_configure,
	input  wire logic           read_response_valid,
	input  wire response_line_t read_response,
	input  wire logic           read_data_valid,
	input  wire data_line_t     read_data,
	input  wire tag_t           read_data_tag,
	input  wire logic           write_response_valid,
	input  wire response_line_t write_response,
	output logic                read_command_valid,
	output command_line_t       read_command,
	output logic                write_command_valid,
	output command_line_t       write_command,
	output data_line_t          write_data,
	output logic [63:0]         cu_return,
	output logic                cu_done,
	output logic [63:0]         cu_status
);

	logic           enabled;
	wed_t           wed_q;
	logic [63:0]    cfg_q;
	logic           read_response_valid_q;
	response_line_t read_response_q;
	logic           read_data_valid_q;
	data_line_t     read_data_q;
	tag_t           read_data_tag_q;
	logic           write_response_valid_q;
	response_line_t write_response_q;

	logic cu_ready;
	logic cu_ready_q;
	logic copy_mode;
	logic read_only_mode;
	logic read_enable;
	logic write_enable;
	logic read_line_valid;
	logic done_now;

	logic          rd_cmd_valid;
	command_line_t rd_cmd;
	logic          rd_push;
	data_line_t    rd_push_data;
	count_t        read_done_count;
	logic          wr_cmd_valid;
	command_line_t wr_cmd;
	data_line_t    wr_data;
	logic          wr_pop;
	count_t        write_done_count;
	data_line_t    fifo_head;
	count_t        fifo_count;
	logic          fifo_empty;
	logic          resp_empty;

	////////////////////
	// Input latch
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled                <= 1'b0;
			wed_q                  <= '0;
			cfg_q                  <= '0;
			read_response_valid_q  <= 1'b0;
			read_data_valid_q      <= 1'b0;
			write_response_valid_q <= 1'b0;
		end else begin
			enabled                <= enabled_in;
			read_response_valid_q  <= enabled && read_response_valid;
			read_data_valid_q      <= enabled && read_data_valid;
			write_response_valid_q <= enabled && write_response_valid;
			// WED held once captured
			if (enabled && wed_valid && !wed_q.valid) begin
				wed_q       <= wed;
				wed_q.valid <= 1'b1;
			end
			// A zero word keeps the previous mode
			if (enabled && (|cu_configure)) begin
				cfg_q <= cu_configure;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enabled) begin
			read_response_q  <= read_response;
			read_data_q      <= read_data;
			read_data_tag_q  <= read_data_tag;
			write_response_q <= write_response;
		end
	end

	////////////////////
	// Mode and enables
	////////////////////

	assign cu_ready       = (|cfg_q) && wed_q.valid;
	assign copy_mode      = cfg_q[CFG_READ_BIT] && cfg_q[CFG_WRITE_BIT];
	assign read_only_mode = cfg_q[CFG_READ_BIT] && !cfg_q[CFG_WRITE_BIT];

	// Two stages from latched setup to running engines
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_ready_q   <= 1'b0;
			read_enable  <= 1'b0;
			write_enable <= 1'b0;
		end else begin
			cu_ready_q   <= enabled && cu_ready;
			read_enable  <= cu_ready_q && cfg_q[CFG_READ_BIT];
			write_enable <= cu_ready_q && copy_mode;
		end
	end

	////////////////////
	// Done and return
	////////////////////

	always_comb begin
		done_now = 1'b0;
		if (wed_q.valid) begin
			if (copy_mode) begin
				done_now = (read_done_count == wed_q.size_send) &&
					(write_done_count == wed_q.size_recive);
			end else if (read_only_mode) begin
				done_now = (read_done_count == wed_q.size_send);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_done   <= 1'b0;
			cu_return <= '0;
			cu_status <= '0;
		end else begin
			cu_done   <= cu_done || done_now;
			cu_return <= copy_mode ? 64'(write_done_count) : 64'(read_done_count);
			cu_status <= cfg_q;
		end
	end

	////////////////////
	// Output registers
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_valid  <= 1'b0;
			write_command_valid <= 1'b0;
		end else begin
			read_command_valid  <= rd_cmd_valid;
			write_command_valid <= wr_cmd_valid;
		end
	end

	always_ff @(posedge clock) begin
		read_command  <= rd_cmd;
		write_command <= wr_cmd;
		write_data    <= wr_data;
	end

	////////////////////
	// Read engine
	////////////////////

	// Line counts only with its own response alongside
	assign read_line_valid = read_data_valid_q && read_response_valid_q &&
		(read_data_tag_q == read_response_q.tag);

	// Responses drained one per cycle
	cu_line_fifo #(
		.payload_t  (response_line_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_response_fifo (
		.clock     (clock),
		.rstn      (rstn),
		.push      (read_response_valid_q),
		.push_data (read_response_q),
		.pop       (!resp_empty),
		.pop_data  (),
		.count     (),
		.empty     (resp_empty),
		.full      ()
	);

	cu_read_engine #(
		.MAX_OUTSTANDING (MAX_OUTSTANDING),
		.FIFO_DEPTH      (FIFO_DEPTH)
	) i_read_engine (
		.clock           (clock),
		.rstn            (rstn),
		.enabled         (read_enable),
		.source_address  (wed_q.source_address),
		.line_total      (wed_q.size_send),
		.response_valid  (!resp_empty),
		.data_valid      (read_line_valid),
		.data_in         (read_data_q),
		.fifo_count      (fifo_count),
		.command_valid   (rd_cmd_valid),
		.command         (rd_cmd),
		.push            (rd_push),
		.push_data       (rd_push_data),
		.read_done_count (read_done_count)
	);

	////////////////////
	// Write engine
	////////////////////

	// Read-only runs drop the lines here
	cu_line_fifo #(
		.payload_t  (data_line_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_data_fifo (
		.clock     (clock),
		.rstn      (rstn),
		.push      (rd_push && copy_mode),
		.push_data (rd_push_data),
		.pop       (wr_pop),
		.pop_data  (fifo_head),
		.count     (fifo_count),
		.empty     (fifo_empty),
		.full      ()
	);

	// In-order write responses carry the write index as tag
	cu_write_engine #(
		.MAX_OUTSTANDING (MAX_OUTSTANDING)
	) i_write_engine (
		.clock               (clock),
		.rstn                (rstn),
		.enabled             (write_enable),
		.destination_address (wed_q.destination_address),
		.line_total          (wed_q.size_recive),
		.fifo_empty          (fifo_empty),
		.pop_data            (fifo_head),
		.response_valid      (write_response_valid_q &&
			(write_response_q.tag == tag_t'(write_done_count))),
		.pop                 (wr_pop),
		.command_valid       (wr_cmd_valid),
		.command             (wr_cmd),
		.data_out            (wr_data),
		.write_done_count    (write_done_count)
	);

endmodule

`default_nettype wire

//--- verilog/cu_line_fifo.sv
/*
 * Line FIFO
 * Circular buffer with first-word-fall-through output,
 * occupancy count and full/empty flags
 */

`timescale 1ns/1ps
`default_nettype none

module cu_line_fifo
	import cu_pkg::*;
#(
	parameter type payload_t  = data_line_t,
	parameter int  FIFO_DEPTH = 8
) (
	input  wire logic     clock,
	input  wire logic     rstn,
	input  wire logic     push,
	input  wire payload_t push_data,
	input  wire logic     pop,
	output payload_t      pop_data,
	output count_t        count,
	output logic          empty,
	output logic          full
);

	localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(FIFO_DEPTH - 1);

	payload_t            mem [FIFO_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic                write_en;
	logic                read_en;

	// A push into a full FIFO only lands when the head leaves
	assign write_en = push && (!full || pop);
	assign read_en  = pop && !empty;

	assign empty    = (count == '0);
	assign full     = (count == count_t'(FIFO_DEPTH));
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (write_en) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (write_en) begin
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			end
			if (read_en) begin
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			end
			case ({write_en, read_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/cu_pkg.sv
/*
 * Copy compute unit shared definitions
 * Command, response, data line and WED types, configuration
 * bit positions and command codes
 */

`default_nettype none

package cu_pkg;

	// Line count width
	parameter int ARRAY_SIZE_BITS = 32;

	// One cache line is 64 bytes
	parameter int LINE_BYTES = 64;

	// Mode bits in cu_configure
	parameter int CFG_READ_BIT  = 23;
	parameter int CFG_WRITE_BIT = 22;

	typedef logic [63:0]                addr_t;
	typedef logic [ARRAY_SIZE_BITS-1:0] count_t;
	typedef logic [7:0]                 tag_t;

	typedef enum logic [1:0] {
		CMD_NONE  = 2'b00,
		CMD_READ  = 2'b01,
		CMD_WRITE = 2'b10
	} cmd_code_t;

	// Command toward host memory
	typedef struct packed {
		cmd_code_t code;
		addr_t     address;
		tag_t      tag;
	} command_line_t;

	typedef struct packed {
		tag_t tag;
	} response_line_t;

	// Full line payload
	typedef logic [511:0] data_line_t;

	// Work element descriptor
	typedef struct packed {
		logic   valid;
		addr_t  source_address;
		addr_t  destination_address;
		count_t size_send;
		count_t size_recive;
	} wed_t;

endpackage

`default_nettype wire

//--- verilog/cu_read_engine.sv
/*
 * Read engine
 * Issues source line reads under a credit limit and forwards
 * the returned lines toward the line FIFO
 */

`timescale 1ns/1ps
`default_nettype none

module cu_read_engine
	import cu_pkg::*;
#(
	parameter int MAX_OUTSTANDING = 4,
	parameter int FIFO_DEPTH      = 8
) (
	input  wire logic       clock,
	input  wire logic       rstn,
	input  wire logic       enabled,
	input  wire addr_t      source_address,
	input  wire count_t     line_total,
	input  wire logic       response_valid,
	input  wire logic       data_valid,
	input  wire data_line_t data_in,
	input  wire count_t     fifo_count,
	output logic            command_valid,
	output command_line_t   command,
	output logic            push,
	output data_line_t      push_data,
	output count_t          read_done_count
);

	count_t issued_count;
	count_t outstanding;
	logic   issue;

	// Stop on credit, or when the FIFO could not hold every line in flight
	assign issue = enabled && (issued_count < line_total) &&
		(outstanding < count_t'(MAX_OUTSTANDING)) &&
		((fifo_count + outstanding) < count_t'(FIFO_DEPTH));

	////////////////////
	// Command issue
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_valid <= 1'b0;
			issued_count  <= '0;
		end else begin
			command_valid <= issue;
			if (issue) begin
				issued_count <= issued_count + 1'b1;
			end
		end
	end

	// Line index sets address and tag
	always_ff @(posedge clock) begin
		command.code    <= CMD_READ;
		command.address <= source_address + (addr_t'(issued_count) * addr_t'(LINE_BYTES));
		command.tag     <= tag_t'(issued_count);
	end

	////////////////////
	// Credits and returns
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding     <= '0;
			read_done_count <= '0;
			push            <= 1'b0;
		end else begin
			case ({issue, response_valid})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
			if (response_valid) begin
				read_done_count <= read_done_count + 1'b1;
			end
			push <= data_valid;
		end
	end

	always_ff @(posedge clock) begin
		push_data <= data_in;
	end

endmodule

`default_nettype wire

//--- verilog/cu_write_engine.sv
/*
 * Write engine
 * Pops lines from the line FIFO, issues destination writes
 * with their data and counts the write responses
 */

`timescale 1ns/1ps
`default_nettype none

module cu_write_engine
	import cu_pkg::*;
#(
	parameter int MAX_OUTSTANDING = 4
) (
	input  wire logic       clock,
	input  wire logic       rstn,
	input  wire logic       enabled,
	input  wire addr_t      destination_address,
	input  wire count_t     line_total,
	input  wire logic       fifo_empty,
	input  wire data_line_t pop_data,
	input  wire logic       response_valid,
	output logic            pop,
	output logic            command_valid,
	output command_line_t   command,
	output data_line_t      data_out,
	output count_t          write_done_count
);

	count_t written_count;
	count_t outstanding;

	// One line per cycle while data and credit are both there
	assign pop = enabled && !fifo_empty && (written_count < line_total) &&
		(outstanding < count_t'(MAX_OUTSTANDING));

	////////////////////
	// Command issue
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_valid <= 1'b0;
			written_count <= '0;
		end else begin
			command_valid <= pop;
			if (pop) begin
				written_count <= written_count + 1'b1;
			end
		end
	end

	// Data travels in the same cycle as its command
	always_ff @(posedge clock) begin
		command.code    <= CMD_WRITE;
		command.address <= destination_address +
			(addr_t'(written_count) * addr_t'(LINE_BYTES));
		command.tag     <= tag_t'(written_count);
		data_out        <= pop_data;
	end

	////////////////////
	// Credits and responses
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding      <= '0;
			write_done_count <= '0;
		end else begin
			case ({pop, response_valid})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
			if (response_valid) begin
				write_done_count <= write_done_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire
